//--- fetch_pkg.sv
package fetch_pkg;

    localparam int XLEN = 64;

    // first instruction after reset
    localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

    // cycles from address transfer to read data valid
    localparam int ROM_LATENCY = 2;

    // depth of the memory model, in 64-bit beats
    localparam int ROM_WORDS = 256;

    // instruction at byte address a is a[31:0] ^ INST_PATTERN
    localparam logic [31:0] INST_PATTERN = 32'h5a5a_0013;

    // byte lanes of one 32-bit instruction
    localparam logic [7:0] READ_SIZE = 8'h0f;

    // memory-stage result as seen by fetch
    typedef struct packed {
        logic            jal;
        logic            jalr;
        logic            branch;
        logic [XLEN-1:0] alu_res;  // zero means branch taken
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] r1data;
    } exec_res_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [31:0]     inst;
    } fetch_out_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] target;
    } redirect_t;

endpackage

//--- pc_redirect.sv
`timescale 1ns/100ps

module pc_redirect (
    input  fetch_pkg::exec_res_t       exec_i,
    input  logic                       trap_i,
    input  logic [fetch_pkg::XLEN-1:0] mtvec_i,
    output fetch_pkg::redirect_t       redirect_o
);

    logic [fetch_pkg::XLEN-1:0] br_target;
    logic [fetch_pkg::XLEN-1:0] jr_sum;
    logic [fetch_pkg::XLEN-1:0] jr_target;
    logic                       br_taken;

    // jal and branches are pc relative
    assign br_target = exec_i.pc + exec_i.imm;

    // jalr drops bit 0 of the sum
    assign jr_sum    = exec_i.r1data + exec_i.imm;
    assign jr_target = {jr_sum[fetch_pkg::XLEN-1:1], 1'b0};

    // branch compare result comes back as zero when taken
    assign br_taken = exec_i.jal || (exec_i.branch && (exec_i.alu_res == '0));

    always_comb begin
        redirect_o = '0;
        if (br_taken) begin
            redirect_o.valid  = 1'b1;
            redirect_o.target = br_target;
        end else if (exec_i.jalr) begin
            redirect_o.valid  = 1'b1;
            redirect_o.target = jr_target;
        end else if (trap_i) begin  // lowest priority
            redirect_o.valid  = 1'b1;
            redirect_o.target = mtvec_i;
        end
    end

endmodule

//--- inst_fetch.sv
`timescale 1ns/100ps

module inst_fetch (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  fetch_pkg::redirect_t       redirect_i,
    input  logic                       hold_i,
    output logic [fetch_pkg::XLEN-1:0] rd_addr_o,
    output logic [7:0]                 rd_size_o,
    output logic                       rd_valid_o,
    input  logic                       rd_ready_i,
    input  logic [fetch_pkg::XLEN-1:0] rd_data_i,
    input  logic                       rd_data_valid_i,
    output logic                       rd_data_ready_o,
    output fetch_pkg::fetch_out_t      fetch_o
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

    rd_state_e                  rd_state_q;
    logic [fetch_pkg::XLEN-1:0] pc_q;
    logic [fetch_pkg::XLEN-1:0] req_addr_q;
    logic [fetch_pkg::XLEN-1:0] fetch_pc_q;
    logic [31:0]                fetch_inst_q;
    logic [31:0]                inst_sel;
    logic                       need_fetch_q;
    logic                       stale_q;
    logic                       fetch_valid_q;
    logic                       issue;
    logic                       addr_xfer;
    logic                       beat_xfer;
    logic                       beat_keep;
    logic                       consume;

    assign rd_addr_o       = req_addr_q;
    assign rd_size_o       = fetch_pkg::READ_SIZE;
    assign rd_valid_o      = (rd_state_q == RD_ADDR);
    assign rd_data_ready_o = (rd_state_q == RD_DATA);

    assign addr_xfer = rd_valid_o && rd_ready_i;
    assign beat_xfer = rd_data_valid_i && rd_data_ready_o;
    assign consume   = fetch_valid_q && !hold_i;  // decode took the instruction

    // a redirect edge never issues, the target goes out on a later edge
    assign issue = (rd_state_q == RD_IDLE) && need_fetch_q && !redirect_i.valid;

    // only a fresh beat for the current pc reaches decode
    assign beat_keep = beat_xfer && !stale_q && !redirect_i.valid && (req_addr_q == pc_q);

    assign inst_sel = req_addr_q[2] ? rd_data_i[63:32] : rd_data_i[31:0];

    // read channel sequencing
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rd_state_q <= RD_IDLE;
            stale_q    <= 1'b0;
        end else begin
            case (rd_state_q)
                RD_IDLE: begin
                    if (issue) begin
                        rd_state_q <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (addr_xfer) begin
                        rd_state_q <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (beat_xfer) begin
                        rd_state_q <= RD_IDLE;
                    end
                end
                default: rd_state_q <= RD_IDLE;
            endcase

            if (beat_xfer) begin
                stale_q <= 1'b0;  // channel free again
            end else if (redirect_i.valid && rd_state_q != RD_IDLE) begin
                stale_q <= 1'b1;  // old request still in flight
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_addr_q <= pc_q;
        end
    end

    // program counter
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q         <= fetch_pkg::RESET_PC;
            need_fetch_q <= 1'b1;
        end else if (redirect_i.valid) begin
            pc_q         <= redirect_i.target;
            need_fetch_q <= 1'b1;
        end else begin
            if (issue) begin
                need_fetch_q <= 1'b0;
            end
            if (consume) begin
                pc_q         <= pc_q + 64'd4;
                need_fetch_q <= 1'b1;
            end
        end
    end

    // output register toward decode
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            fetch_valid_q <= 1'b0;
        end else if (redirect_i.valid) begin
            fetch_valid_q <= 1'b0;  // held instruction is discarded
        end else if (beat_keep) begin
            fetch_valid_q <= 1'b1;
        end else if (consume) begin
            fetch_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_keep) begin
            fetch_pc_q   <= req_addr_q;
            fetch_inst_q <= inst_sel;
        end
    end

    always_comb begin
        fetch_o.valid = fetch_valid_q;
        fetch_o.pc    = fetch_pc_q;
        fetch_o.inst  = fetch_inst_q;
    end

endmodule

//--- inst_rom.sv
`timescale 1ns/100ps

module inst_rom (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic [fetch_pkg::XLEN-1:0] rd_addr_i,
    input  logic [7:0]                 rd_size_i,
    input  logic                       rd_valid_i,
    output logic                       rd_ready_o,
    output logic [fetch_pkg::XLEN-1:0] rd_data_o,
    output logic                       rd_data_valid_o,
    input  logic                       rd_data_ready_i
);

    typedef enum logic [1:0] {
        ROM_IDLE,
        ROM_WAIT,
        ROM_DATA
    } rom_state_e;

    logic [fetch_pkg::XLEN-1:0] mem [fetch_pkg::ROM_WORDS];
    rom_state_e                 state_q;
    logic [fetch_pkg::XLEN-1:0] offset;
    logic [$clog2(fetch_pkg::ROM_WORDS)-1:0] idx_q;
    logic [7:0]                 cnt_q;
    logic [fetch_pkg::XLEN-1:0] data_q;

    // both halves of beat idx follow the address pattern
    function automatic logic [63:0] rom_beat(input int unsigned idx);
        logic [31:0] lo_addr;
        lo_addr = fetch_pkg::RESET_PC[31:0] + 32'(idx) * 32'd8;
        return {(lo_addr + 32'd4) ^ fetch_pkg::INST_PATTERN, lo_addr ^ fetch_pkg::INST_PATTERN};
    endfunction

    assign offset          = rd_addr_i - fetch_pkg::RESET_PC;  // rom is based at RESET_PC
    assign rd_ready_o      = (state_q == ROM_IDLE);
    assign rd_data_valid_o = (state_q == ROM_DATA);
    assign rd_data_o       = data_q;  // full beat, rd_size_i lanes are not masked

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < fetch_pkg::ROM_WORDS; i++) begin
                mem[i] <= rom_beat(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ROM_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                ROM_IDLE: begin
                    if (rd_valid_i) begin
                        state_q <= ROM_WAIT;
                        cnt_q   <= 8'(fetch_pkg::ROM_LATENCY - 1);
                    end
                end
                ROM_WAIT: begin
                    if (cnt_q == '0) begin
                        state_q <= ROM_DATA;
                    end else begin
                        cnt_q <= cnt_q - 8'd1;
                    end
                end
                ROM_DATA: begin
                    if (rd_data_ready_i) begin  // beat taken
                        state_q <= ROM_IDLE;
                    end
                end
                default: state_q <= ROM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid_i && rd_ready_o) begin
            idx_q <= offset[$clog2(fetch_pkg::ROM_WORDS)+2:3];
        end
        if (state_q == ROM_WAIT && cnt_q == '0) begin
            data_q <= mem[idx_q];
        end
    end

endmodule

//--- fetch_top.sv
`timescale 1ns/100ps

module fetch_top (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  fetch_pkg::exec_res_t       exec_i,
    input  logic                       trap_i,
    input  logic [fetch_pkg::XLEN-1:0] mtvec_i,
    input  logic                       hold_i,
    output fetch_pkg::fetch_out_t      fetch_o
);

    fetch_pkg::redirect_t       redirect;
    logic [fetch_pkg::XLEN-1:0] rd_addr;
    logic [7:0]                 rd_size;
    logic                       rd_valid;
    logic                       rd_ready;
    logic [fetch_pkg::XLEN-1:0] rd_data;
    logic                       rd_data_valid;
    logic                       rd_data_ready;

    pc_redirect pc_redirect_inst (
        .exec_i     (exec_i),
        .trap_i     (trap_i),
        .mtvec_i    (mtvec_i),
        .redirect_o (redirect)
    );

    inst_fetch inst_fetch_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .redirect_i      (redirect),
        .hold_i          (hold_i),
        .rd_addr_o       (rd_addr),
        .rd_size_o       (rd_size),
        .rd_valid_o      (rd_valid),
        .rd_ready_i      (rd_ready),
        .rd_data_i       (rd_data),
        .rd_data_valid_i (rd_data_valid),
        .rd_data_ready_o (rd_data_ready),
        .fetch_o         (fetch_o)
    );

    inst_rom inst_rom_inst (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .rd_addr_i       (rd_addr),
        .rd_size_i       (rd_size),
        .rd_valid_i      (rd_valid),
        .rd_ready_o      (rd_ready),
        .rd_data_o       (rd_data),
        .rd_data_valid_o (rd_data_valid),
        .rd_data_ready_i (rd_data_ready)
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n_o
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n_o = 1'b1;  // released between edges
    end

endmodule

//--- fetch_asserts.sv
`timescale 1ns/100ps

module fetch_asserts (
    input logic                       clk,
    input logic                       rst_n_i,
    input logic                       rd_valid_i,
    input logic                       rd_ready_i,
    input logic [fetch_pkg::XLEN-1:0] rd_addr_i,
    input fetch_pkg::fetch_out_t      fetch_i
);

    // address held while the request waits for ready
    property addr_stable_p;
        @(posedge clk) disable iff (!rst_n_i)
            (rd_valid_i && !rd_ready_i) |=> (rd_valid_i && $stable(rd_addr_i));
    endproperty

    property valid_low_after_reset_p;
        @(posedge clk) !rst_n_i |=> !fetch_i.valid;
    endproperty

    // decode only ever sees word aligned pcs
    property pc_aligned_p;
        @(posedge clk) disable iff (!rst_n_i)
            fetch_i.valid |-> (fetch_i.pc[1:0] == 2'b00);
    endproperty

    addr_stable_a: assert property (addr_stable_p)
        else $error("read address changed while waiting for ready");
    valid_low_after_reset_a: assert property (valid_low_after_reset_p)
        else $error("fetch output valid in the cycle after reset");
    pc_aligned_a: assert property (pc_aligned_p)
        else $error("delivered pc is not a multiple of 4");

endmodule

//--- fetch_tb.sv
`timescale 1ns/100ps

module fetch_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int NUM_TESTS    = 5;
    localparam int MAX_FETCHES  = 20;  // longest test, holds included
    localparam int FETCH_CYCLES = fetch_pkg::ROM_LATENCY + 3;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * MAX_FETCHES * FETCH_CYCLES + 200;

    logic                       clk;
    logic                       rst_n;
    fetch_pkg::exec_res_t       exec_i;
    logic                       trap_i;
    logic [fetch_pkg::XLEN-1:0] mtvec_i;
    logic                       hold_i;
    fetch_pkg::fetch_out_t      fetch_o;

    int          pass_cnt = 0;
    int          fail_cnt = 0;
    logic [63:0] exp_pc;  // next pc decode should see

    tb_clock_gen tb_clock_gen_inst (.clk(clk), .rst_n_o(rst_n));

    fetch_top fetch_top_inst (
        .clk     (clk),
        .rst_n_i (rst_n),
        .exec_i  (exec_i),
        .trap_i  (trap_i),
        .mtvec_i (mtvec_i),
        .hold_i  (hold_i),
        .fetch_o (fetch_o)
    );

    bind inst_fetch fetch_asserts fetch_asserts_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rd_valid_i (rd_valid_o),
        .rd_ready_i (rd_ready_i),
        .rd_addr_i  (rd_addr_o),
        .fetch_i    (fetch_o)
    );

    function automatic logic [31:0] expected_inst(input logic [63:0] pc);
        return pc[31:0] ^ fetch_pkg::INST_PATTERN;
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        assert (actual === expected) pass_cnt++;
        else begin
            $display("ERROR %s: %s expected %h actual %h", test, what, expected, actual);
            fail_cnt++;
        end
    endtask

    task automatic check_output(input string test);
        check_value(test, "pc", exp_pc, fetch_o.pc);
        check_value(test, "inst", 64'(expected_inst(exp_pc)), 64'(fetch_o.inst));
    endtask

    // waits for a valid output, checks it and lets it be consumed (hold_i low)
    task automatic next_inst(input string test);
        while (!fetch_o.valid) @(negedge clk);
        check_output(test);
        @(negedge clk);
        exp_pc = exp_pc + 64'd4;
    endtask

    // one cycle pulse, starting at the current falling edge
    task automatic send_redirect(input fetch_pkg::exec_res_t ex, input logic trap,
                                 input logic [63:0] mtvec);
        exec_i  = ex;
        trap_i  = trap;
        mtvec_i = mtvec;
        @(negedge clk);
        exec_i  = '0;
        trap_i  = 1'b0;
        mtvec_i = '0;
    endtask

    task automatic report_test(input string test, input int errs_before);
        if (fail_cnt == errs_before) $display("test %s: ok", test);
        else $display("test %s: %0d errors", test, fail_cnt - errs_before);
    endtask

    task automatic test_sequential();
        int errs0;
        errs0  = fail_cnt;
        exp_pc = fetch_pkg::RESET_PC;
        repeat (10) next_inst("sequential");
        report_test("sequential", errs0);
    endtask

    task automatic test_stall();
        int errs0;
        int n;
        errs0  = fail_cnt;
        hold_i = 1'b1;
        while (!fetch_o.valid) @(negedge clk);
        check_output("stall");
        n = $urandom_range(2, 9);
        repeat (n) begin
            @(negedge clk);
            check_value("stall", "valid", 64'd1, 64'(fetch_o.valid));
            check_output("stall");
        end
        hold_i = 1'b0;
        @(negedge clk);  // consumed here
        exp_pc = exp_pc + 64'd4;
        repeat (3) next_inst("stall");
        report_test("stall", errs0);
    endtask

    task automatic test_jump_branch();
        int                   errs0;
        longint               imm;
        fetch_pkg::exec_res_t ex;
        errs0 = fail_cnt;
        next_inst("jal_branch");
        ex     = '0;
        ex.jal = 1'b1;
        ex.pc  = fetch_pkg::RESET_PC + 64'h200;
        imm    = (longint'($urandom_range(0, 100)) - 50) * 4;
        ex.imm = 64'(imm);
        send_redirect(ex, 1'b0, '0);
        exp_pc = ex.pc + ex.imm;
        repeat (3) next_inst("jal_branch");
        // taken branch, alu result zero
        ex        = '0;
        ex.branch = 1'b1;
        ex.pc     = fetch_pkg::RESET_PC + 64'h300;
        imm       = (longint'($urandom_range(0, 100)) - 50) * 4;
        ex.imm    = 64'(imm);
        send_redirect(ex, 1'b0, '0);
        exp_pc = ex.pc + ex.imm;
        repeat (3) next_inst("jal_branch");
        ex.alu_res = 64'($urandom_range(1, 1000));  // not taken
        send_redirect(ex, 1'b0, '0);
        repeat (3) next_inst("jal_branch");
        report_test("jal_branch", errs0);
    endtask

    task automatic test_jalr();
        int                   errs0;
        logic [63:0]          sum;
        fetch_pkg::exec_res_t ex;
        errs0     = fail_cnt;
        ex        = '0;
        ex.jalr   = 1'b1;
        ex.r1data = fetch_pkg::RESET_PC + 64'h401;  // odd sum, bit 0 dropped
        ex.imm    = 64'($urandom_range(0, 64)) * 64'd4;
        hold_i    = 1'b1;
        while (!fetch_o.valid) @(negedge clk);
        check_output("jalr");
        send_redirect(ex, 1'b0, '0);  // discards the held output
        hold_i = 1'b0;
        sum    = ex.r1data + ex.imm;
        exp_pc = {sum[63:1], 1'b0};
        repeat (3) next_inst("jalr");
        repeat (2) @(negedge clk);  // next read now in flight
        ex.r1data = fetch_pkg::RESET_PC + 64'h101;
        ex.imm    = 64'($urandom_range(0, 64)) * 64'd4;
        send_redirect(ex, 1'b0, '0);
        sum    = ex.r1data + ex.imm;
        exp_pc = {sum[63:1], 1'b0};
        repeat (3) next_inst("jalr");
        report_test("jalr", errs0);
    endtask

    task automatic test_trap();
        int                   errs0;
        fetch_pkg::exec_res_t ex;
        errs0 = fail_cnt;
        ex    = '0;
        send_redirect(ex, 1'b1, fetch_pkg::RESET_PC + 64'h700);
        exp_pc = fetch_pkg::RESET_PC + 64'h700;
        repeat (3) next_inst("trap");
        // jal and trap together, jal has priority
        ex.jal = 1'b1;
        ex.pc  = fetch_pkg::RESET_PC + 64'h80;
        ex.imm = 64'($urandom_range(0, 32)) * 64'd4;
        send_redirect(ex, 1'b1, fetch_pkg::RESET_PC + 64'h600);
        exp_pc = ex.pc + ex.imm;
        repeat (3) next_inst("trap");
        report_test("trap", errs0);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run stopped after %0d cycles without finishing", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

    initial begin
        void'($urandom(16));
        exec_i  = '0;
        trap_i  = 1'b0;
        mtvec_i = '0;
        hold_i  = 1'b0;
        @(posedge rst_n);
        test_sequential();
        test_stall();
        test_jump_branch();
        test_jalr();
        test_trap();
        $display("checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- fetch_subsys.f
fetch_pkg.sv
pc_redirect.sv
inst_fetch.sv
inst_rom.sv
fetch_top.sv
tb_clock_gen.sv
fetch_asserts.sv
fetch_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module fetch_tb -f fetch_subsys.f -o fetch_sim \
    && ./obj_dir/fetch_sim > sim.log 2>&1
[ -f sim.log ] && cat sim.log
grep -q -x "Everything OK" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
